// File: mem_unit_pkg.sv
/* Memory unit shared definitions */

`default_nettype none

package mem_unit_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ADDR_W = 40;              // Physical address
    localparam int XLEN   = 64;              // Data and register width
    localparam int RD_W   = 5;               // Destination register number
    localparam int TAG_W  = 8;               // Cache tag

    // Address map
    localparam logic [ADDR_W-1:0] IO_BASE_ADDR = 40'h00_4000_0000;
    localparam logic [ADDR_W-1:0] IO_END_ADDR  = 40'h00_8000_0000; // First address past IO

    // Model memory and timing
    localparam int MEM_WORDS   = 16;         // Doublewords, addr[6:3]
    localparam int MEM_LATENCY = 2;          // Accept to response
    localparam int WAIT_LIMIT  = 8;          // Cycles before bus error
    localparam int TMR_W       = $clog2(WAIT_LIMIT + 1);

    // CPU instruction types
    typedef enum logic [3:0] {
        NOP, LD, SD, LR_D, SC_D,
        AMO_SWAPD, AMO_ADDD, AMO_XORD, AMO_ANDD, AMO_ORD,
        AMO_MIND, AMO_MAXD, AMO_MINDU, AMO_MAXDU
    } instr_type_e;

    // Cache command codes, RISC-V style
    typedef enum logic [4:0] {
        CMD_LOAD    = 5'b00000,
        CMD_STORE   = 5'b00001,
        CMD_AMOSWAP = 5'b00100,
        CMD_LR      = 5'b00110,
        CMD_SC      = 5'b00111,
        CMD_AMOADD  = 5'b01000,
        CMD_AMOXOR  = 5'b01001,
        CMD_AMOOR   = 5'b01010,
        CMD_AMOAND  = 5'b01011,
        CMD_AMOMIN  = 5'b01100,
        CMD_AMOMAX  = 5'b01101,
        CMD_AMOMINU = 5'b01110,
        CMD_AMOMAXU = 5'b01111
    } dmem_cmd_e;

    // Operation class for PMU
    typedef enum logic [1:0] {
        MEM_NOP, MEM_LOAD, MEM_STORE, MEM_AMO
    } mem_op_e;

    // Control FSM states
    typedef enum logic [1:0] {
        IDLE, ISSUE, WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: wait_timer.sv
/* Access wait timer */

`timescale 1ns/1ps
`default_nettype none

module wait_timer (
    input  wire  clk_i,
    input  wire  arst_n_i,
    input  logic run_i,          // Access outstanding
    output logic expired_o       // One-cycle timeout pulse
);

    logic [mem_unit_pkg::TMR_W-1:0] cnt_q;

    // Saturating counter, cleared while idle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            expired_o <= 1'b0;
        end else if (!run_i) begin
            cnt_q     <= '0;
            expired_o <= 1'b0;
        end else begin
            if (cnt_q != mem_unit_pkg::TMR_W'(mem_unit_pkg::WAIT_LIMIT))
                cnt_q <= cnt_q + 1'b1;
            // Fires once, count then sticks at the limit
            expired_o <= (cnt_q == mem_unit_pkg::TMR_W'(mem_unit_pkg::WAIT_LIMIT - 1));
        end
    end

endmodule

`default_nettype wire

// File: mem_ctrl_fsm.sv
/* Memory request control FSM */

`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_fsm (
    input  wire                                 clk_i,
    input  wire                                 arst_n_i,
    input  logic                                req_valid_i,
    input  mem_unit_pkg::instr_type_e           req_instr_i,
    input  logic [mem_unit_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic [mem_unit_pkg::XLEN-1:0]       req_data_i,
    input  logic [mem_unit_pkg::RD_W-1:0]       req_rd_i,
    input  logic                                kill_i,
    input  logic                                io_space_i,        // Current access is IO
    input  logic                                dmem_resp_valid_i,
    input  logic                                expired_i,
    output mem_unit_pkg::instr_type_e           cur_instr_o,       // Held request
    output logic [mem_unit_pkg::ADDR_W-1:0]     cur_addr_o,
    output logic [mem_unit_pkg::XLEN-1:0]       cur_data_o,
    output logic [mem_unit_pkg::RD_W-1:0]       cur_rd_o,
    output logic                                cur_kill_o,
    output logic                                dmem_req_valid_o,
    output logic                                timer_run_o,
    output logic                                done_o,            // Response pulse
    output logic                                timeout_o,         // With done_o on expiry
    output logic                                busy_o
);

    mem_unit_pkg::ctrl_state_e state_q;
    logic                      accept;

    assign accept = (state_q == mem_unit_pkg::IDLE) && req_valid_i;

    // ----------------------------------------
    // State and control
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= mem_unit_pkg::IDLE;
            cur_kill_o <= 1'b0;
            done_o     <= 1'b0;
            timeout_o  <= 1'b0;
        end else begin
            done_o    <= 1'b0;   // Pulses by default
            timeout_o <= 1'b0;
            case (state_q)
                mem_unit_pkg::IDLE: if (accept) begin
                    cur_kill_o <= kill_i;
                    state_q    <= mem_unit_pkg::ISSUE;
                end
                mem_unit_pkg::ISSUE: if (cur_kill_o) begin
                    done_o  <= 1'b1;     // Killed, nothing sent
                    state_q <= mem_unit_pkg::IDLE;
                end else begin
                    state_q <= mem_unit_pkg::WAIT;
                end
                mem_unit_pkg::WAIT: if (expired_i) begin
                    done_o    <= 1'b1;
                    timeout_o <= 1'b1;
                    state_q   <= mem_unit_pkg::IDLE;
                end else if (dmem_resp_valid_i && !io_space_i) begin
                    done_o  <= 1'b1;     // IO ends only by timeout
                    state_q <= mem_unit_pkg::IDLE;
                end
                default: state_q <= mem_unit_pkg::IDLE;
            endcase
        end
    end

    // Request payload, loaded on accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cur_instr_o <= req_instr_i;
            cur_addr_o  <= req_addr_i;
            cur_data_o  <= req_data_i;
            cur_rd_o    <= req_rd_i;
        end
    end

    assign dmem_req_valid_o = (state_q == mem_unit_pkg::ISSUE) && !cur_kill_o;
    assign timer_run_o      = (state_q == mem_unit_pkg::WAIT);
    assign busy_o           = (state_q != mem_unit_pkg::IDLE);

endmodule

`default_nettype wire

// File: dcache_interface.sv
/* Data cache interface */

`timescale 1ns/1ps
`default_nettype none

module dcache_interface (
    input  mem_unit_pkg::instr_type_e           req_instr_i,
    input  logic [mem_unit_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic [mem_unit_pkg::XLEN-1:0]       req_data_i,
    input  logic [mem_unit_pkg::RD_W-1:0]       req_rd_i,
    input  logic                                kill_i,
    input  logic                                req_valid_i,       // Issue strobe
    input  logic                                done_i,
    input  logic                                timeout_i,
    input  logic [mem_unit_pkg::XLEN-1:0]       dmem_resp_data_i,
    input  logic [mem_unit_pkg::TAG_W-1:0]      dmem_resp_tag_i,
    input  logic                                dmem_xcpt_ma_i,
    output mem_unit_pkg::dmem_cmd_e             dmem_req_cmd_o,
    output logic [mem_unit_pkg::ADDR_W-1:0]     dmem_req_addr_o,
    output logic [mem_unit_pkg::XLEN-1:0]       dmem_req_data_o,
    output logic [mem_unit_pkg::TAG_W-1:0]      dmem_req_tag_o,
    output logic                                dmem_req_kill_o,
    output logic                                io_space_o,
    output logic                                resp_valid_o,
    output logic [mem_unit_pkg::XLEN-1:0]       resp_data_o,
    output logic [mem_unit_pkg::RD_W-1:0]       resp_rd_o,
    output logic [mem_unit_pkg::ADDR_W-1:0]     resp_addr_o,
    output logic                                resp_xcpt_ma_o,
    output logic                                resp_xcpt_bus_o,
    output logic                                is_load_o,
    output logic                                is_store_o
);

    mem_unit_pkg::mem_op_e op_class;

    // ----------------------------------------
    // Command decode
    // ----------------------------------------
    always_comb begin
        op_class       = mem_unit_pkg::MEM_AMO;   // Most types are atomics
        dmem_req_cmd_o = mem_unit_pkg::CMD_LOAD;
        case (req_instr_i)
            mem_unit_pkg::LD: begin
                dmem_req_cmd_o = mem_unit_pkg::CMD_LOAD;
                op_class       = mem_unit_pkg::MEM_LOAD;
            end
            mem_unit_pkg::SD: begin
                dmem_req_cmd_o = mem_unit_pkg::CMD_STORE;
                op_class       = mem_unit_pkg::MEM_STORE;
            end
            mem_unit_pkg::LR_D:      dmem_req_cmd_o = mem_unit_pkg::CMD_LR;
            mem_unit_pkg::SC_D:      dmem_req_cmd_o = mem_unit_pkg::CMD_SC;
            mem_unit_pkg::AMO_SWAPD: dmem_req_cmd_o = mem_unit_pkg::CMD_AMOSWAP;
            mem_unit_pkg::AMO_ADDD:  dmem_req_cmd_o = mem_unit_pkg::CMD_AMOADD;
            mem_unit_pkg::AMO_XORD:  dmem_req_cmd_o = mem_unit_pkg::CMD_AMOXOR;
            mem_unit_pkg::AMO_ANDD:  dmem_req_cmd_o = mem_unit_pkg::CMD_AMOAND;
            mem_unit_pkg::AMO_ORD:   dmem_req_cmd_o = mem_unit_pkg::CMD_AMOOR;
            mem_unit_pkg::AMO_MIND:  dmem_req_cmd_o = mem_unit_pkg::CMD_AMOMIN;
            mem_unit_pkg::AMO_MAXD:  dmem_req_cmd_o = mem_unit_pkg::CMD_AMOMAX;
            mem_unit_pkg::AMO_MINDU: dmem_req_cmd_o = mem_unit_pkg::CMD_AMOMINU;
            mem_unit_pkg::AMO_MAXDU: dmem_req_cmd_o = mem_unit_pkg::CMD_AMOMAXU;
            default:                 op_class       = mem_unit_pkg::MEM_NOP;
        endcase
    end

    // IO window, memory never answers there
    assign io_space_o = (req_addr_i >= mem_unit_pkg::IO_BASE_ADDR) &&
                        (req_addr_i <  mem_unit_pkg::IO_END_ADDR);

    assign dmem_req_addr_o = req_addr_i;
    assign dmem_req_data_o = req_data_i;
    assign dmem_req_tag_o  = {2'b00, req_rd_i, 1'b0};   // rd in bits 5..1
    assign dmem_req_kill_o = kill_i | io_space_o;

    // ----------------------------------------
    // CPU response
    // ----------------------------------------
    assign resp_valid_o    = done_i;
    assign resp_data_o     = (timeout_i || kill_i) ? '0 : dmem_resp_data_i;
    assign resp_rd_o       = dmem_resp_tag_i[5:1];
    assign resp_addr_o     = req_addr_i;
    assign resp_xcpt_ma_o  = dmem_xcpt_ma_i && !timeout_i && !kill_i; // Stale flag otherwise
    assign resp_xcpt_bus_o = timeout_i;

    // PMU strobes, only for requests that reach memory
    assign is_load_o  = req_valid_i && !dmem_req_kill_o && (op_class == mem_unit_pkg::MEM_LOAD);
    assign is_store_o = req_valid_i && !dmem_req_kill_o && (op_class == mem_unit_pkg::MEM_STORE);

endmodule

`default_nettype wire

// File: dmem_model.sv
/* Behavioural data memory */

`timescale 1ns/1ps
`default_nettype none

module dmem_model (
    input  wire                                 clk_i,
    input  wire                                 arst_n_i,
    input  logic                                req_valid_i,
    input  mem_unit_pkg::dmem_cmd_e             req_cmd_i,
    input  logic [mem_unit_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic [mem_unit_pkg::XLEN-1:0]       req_data_i,
    input  logic [mem_unit_pkg::TAG_W-1:0]      req_tag_i,
    input  logic                                req_kill_i,
    output logic                                resp_valid_o,
    output logic [mem_unit_pkg::XLEN-1:0]       resp_data_o,
    output logic [mem_unit_pkg::TAG_W-1:0]      resp_tag_o,
    output logic                                xcpt_ma_o
);

    localparam int LAT = mem_unit_pkg::MEM_LATENCY;

    logic [mem_unit_pkg::XLEN-1:0]   mem [mem_unit_pkg::MEM_WORDS];
    logic [3:0]                      idx;
    logic [mem_unit_pkg::XLEN-1:0]   old_data, wr_data, rd_data;
    logic                            accept, misaligned, wr_en, sc_ok;
    logic                            resv_valid_q;
    logic [mem_unit_pkg::ADDR_W-1:0] resv_addr_q;

    // Response delay line
    logic                            vld_q  [LAT];
    logic [mem_unit_pkg::XLEN-1:0]   data_q [LAT];
    logic [mem_unit_pkg::TAG_W-1:0]  tag_q  [LAT];
    logic                            ma_q   [LAT];

    // ----------------------------------------
    // Access execution
    // ----------------------------------------
    always_comb begin
        idx        = req_addr_i[6:3];
        old_data   = mem[idx];
        accept     = req_valid_i && !req_kill_i;           // Killed ones dropped
        misaligned = |req_addr_i[2:0];
        sc_ok      = resv_valid_q && (resv_addr_q == req_addr_i);
        wr_en      = 1'b1;
        rd_data    = old_data;                              // Old value for load and AMO
        wr_data    = req_data_i;
        case (req_cmd_i)
            mem_unit_pkg::CMD_LOAD, mem_unit_pkg::CMD_LR: wr_en = 1'b0;
            mem_unit_pkg::CMD_SC: begin
                wr_en   = sc_ok;
                rd_data = {{(mem_unit_pkg::XLEN-1){1'b0}}, !sc_ok}; // 0 on success
            end
            mem_unit_pkg::CMD_AMOADD: wr_data = old_data + req_data_i;
            mem_unit_pkg::CMD_AMOXOR: wr_data = old_data ^ req_data_i;
            mem_unit_pkg::CMD_AMOAND: wr_data = old_data & req_data_i;
            mem_unit_pkg::CMD_AMOOR:  wr_data = old_data | req_data_i;
            mem_unit_pkg::CMD_AMOMIN:
                wr_data = ($signed(req_data_i) < $signed(old_data)) ? req_data_i : old_data;
            mem_unit_pkg::CMD_AMOMAX:
                wr_data = ($signed(req_data_i) > $signed(old_data)) ? req_data_i : old_data;
            mem_unit_pkg::CMD_AMOMINU: wr_data = (req_data_i < old_data) ? req_data_i : old_data;
            mem_unit_pkg::CMD_AMOMAXU: wr_data = (req_data_i > old_data) ? req_data_i : old_data;
            default: ;                                      // Store and swap write req data
        endcase
        if (misaligned) begin
            wr_en   = 1'b0;
            rd_data = '0;
        end
    end

    // Storage array
    always_ff @(posedge clk_i) begin
        if (accept && wr_en)
            mem[idx] <= wr_data;
    end

    // Single reservation
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resv_valid_q <= 1'b0;
        end else if (accept && !misaligned) begin
            if (req_cmd_i == mem_unit_pkg::CMD_LR)
                resv_valid_q <= 1'b1;
            else if (req_cmd_i == mem_unit_pkg::CMD_SC)
                resv_valid_q <= 1'b0;
            else if (wr_en && req_addr_i == resv_addr_q)
                resv_valid_q <= 1'b0;                      // Store or AMO hit
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !misaligned && req_cmd_i == mem_unit_pkg::CMD_LR)
            resv_addr_q <= req_addr_i;
    end

    // ----------------------------------------
    // Latency pipe
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < LAT; i++)
                vld_q[i] <= 1'b0;
        end else begin
            vld_q[0] <= accept;
            for (int i = 1; i < LAT; i++)
                vld_q[i] <= vld_q[i-1];
        end
    end

    // Payload moves only with a valid, so the last answer stays visible
    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q[0] <= rd_data;
            tag_q[0]  <= req_tag_i;
            ma_q[0]   <= misaligned;
        end
        for (int i = 1; i < LAT; i++) begin
            if (vld_q[i-1]) begin
                data_q[i] <= data_q[i-1];
                tag_q[i]  <= tag_q[i-1];
                ma_q[i]   <= ma_q[i-1];
            end
        end
    end

    assign resp_valid_o = vld_q[LAT-1];
    assign resp_data_o  = data_q[LAT-1];
    assign resp_tag_o   = tag_q[LAT-1];
    assign xcpt_ma_o    = ma_q[LAT-1];

endmodule

`default_nettype wire

// File: mem_unit_top.sv
/* Load/store unit top */

`timescale 1ns/1ps
`default_nettype none

module mem_unit_top (
    input  wire                                 clk_i,
    input  wire                                 arst_n_i,
    input  logic                                req_valid_i,
    input  mem_unit_pkg::instr_type_e           req_instr_i,
    input  logic [mem_unit_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic [mem_unit_pkg::XLEN-1:0]       req_data_i,
    input  logic [mem_unit_pkg::RD_W-1:0]       req_rd_i,
    input  logic                                kill_i,
    output logic                                busy_o,
    output logic                                resp_valid_o,
    output logic [mem_unit_pkg::XLEN-1:0]       resp_data_o,
    output logic [mem_unit_pkg::RD_W-1:0]       resp_rd_o,
    output logic [mem_unit_pkg::ADDR_W-1:0]     resp_addr_o,
    output logic                                resp_xcpt_ma_o,
    output logic                                resp_xcpt_bus_o,
    output logic                                is_load_o,
    output logic                                is_store_o
);

    // Held request
    mem_unit_pkg::instr_type_e       cur_instr;
    logic [mem_unit_pkg::ADDR_W-1:0] cur_addr;
    logic [mem_unit_pkg::XLEN-1:0]   cur_data;
    logic [mem_unit_pkg::RD_W-1:0]   cur_rd;
    logic                            cur_kill, io_space, done, timeout, timer_run, expired;

    // Memory request and answer
    mem_unit_pkg::dmem_cmd_e         dmem_req_cmd;
    logic [mem_unit_pkg::ADDR_W-1:0] dmem_req_addr;
    logic [mem_unit_pkg::XLEN-1:0]   dmem_req_data, dmem_resp_data;
    logic [mem_unit_pkg::TAG_W-1:0]  dmem_req_tag, dmem_resp_tag;
    logic                            dmem_req_valid, dmem_req_kill, dmem_resp_valid, dmem_xcpt_ma;

    mem_ctrl_fsm u_fsm (
        .clk_i, .arst_n_i, .req_valid_i, .req_instr_i, .req_addr_i, .req_data_i,
        .req_rd_i, .kill_i,
        .io_space_i        (io_space),
        .dmem_resp_valid_i (dmem_resp_valid),
        .expired_i         (expired),
        .cur_instr_o       (cur_instr),
        .cur_addr_o        (cur_addr),
        .cur_data_o        (cur_data),
        .cur_rd_o          (cur_rd),
        .cur_kill_o        (cur_kill),
        .dmem_req_valid_o  (dmem_req_valid),
        .timer_run_o       (timer_run),
        .done_o            (done),
        .timeout_o         (timeout),
        .busy_o
    );

    wait_timer u_timer (
        .clk_i, .arst_n_i,
        .run_i     (timer_run),
        .expired_o (expired)
    );

    dcache_interface u_dcache_if (
        .req_instr_i      (cur_instr),
        .req_addr_i       (cur_addr),
        .req_data_i       (cur_data),
        .req_rd_i         (cur_rd),
        .kill_i           (cur_kill),
        .req_valid_i      (dmem_req_valid),
        .done_i           (done),
        .timeout_i        (timeout),
        .dmem_resp_data_i (dmem_resp_data),
        .dmem_resp_tag_i  (dmem_resp_tag),
        .dmem_xcpt_ma_i   (dmem_xcpt_ma),
        .dmem_req_cmd_o   (dmem_req_cmd),
        .dmem_req_addr_o  (dmem_req_addr),
        .dmem_req_data_o  (dmem_req_data),
        .dmem_req_tag_o   (dmem_req_tag),
        .dmem_req_kill_o  (dmem_req_kill),
        .io_space_o       (io_space),
        .resp_valid_o, .resp_data_o, .resp_rd_o, .resp_addr_o,
        .resp_xcpt_ma_o, .resp_xcpt_bus_o, .is_load_o, .is_store_o
    );

    dmem_model u_dmem (
        .clk_i, .arst_n_i,
        .req_valid_i  (dmem_req_valid),
        .req_cmd_i    (dmem_req_cmd),
        .req_addr_i   (dmem_req_addr),
        .req_data_i   (dmem_req_data),
        .req_tag_i    (dmem_req_tag),
        .req_kill_i   (dmem_req_kill),
        .resp_valid_o (dmem_resp_valid),
        .resp_data_o  (dmem_resp_data),
        .resp_tag_o   (dmem_resp_tag),
        .xcpt_ma_o    (dmem_xcpt_ma)
    );

endmodule

`default_nettype wire

// File: tb_mem_unit.sv
/* Load/store unit testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_unit;

    localparam int MAX_TESTS = 40;

    logic                            clk, arst_n, req_valid, kill;
    mem_unit_pkg::instr_type_e       req_instr;
    logic [mem_unit_pkg::ADDR_W-1:0] req_addr;
    logic [mem_unit_pkg::XLEN-1:0]   req_data;
    logic [mem_unit_pkg::RD_W-1:0]   req_rd;
    logic                            busy, resp_valid, resp_xcpt_ma, resp_xcpt_bus;
    logic                            is_load, is_store;
    logic [mem_unit_pkg::XLEN-1:0]   resp_data;
    logic [mem_unit_pkg::RD_W-1:0]   resp_rd;
    logic [mem_unit_pkg::ADDR_W-1:0] resp_addr;

    // Stimulus and expected table
    mem_unit_pkg::instr_type_e       tbl_instr [MAX_TESTS];
    logic [mem_unit_pkg::ADDR_W-1:0] tbl_addr  [MAX_TESTS];
    logic [63:0]                     tbl_data  [MAX_TESTS];
    logic [4:0]                      tbl_rd    [MAX_TESTS];
    logic                            tbl_kill  [MAX_TESTS];
    logic                            tbl_extra [MAX_TESTS]; // Second pulse while busy
    logic [63:0]                     exp_data  [MAX_TESTS];
    logic                            exp_ma [MAX_TESTS], exp_bus [MAX_TESTS];
    logic                            exp_ld [MAX_TESTS], exp_st [MAX_TESTS], chk_rd [MAX_TESTS];

    // Shadow memory and reservation
    logic [63:0] shadow_mem [16];
    logic        resv_valid;
    logic [mem_unit_pkg::ADDR_W-1:0] resv_addr;

    int          n_tests, n_err, n_bad_tests, cycles, cycle_limit;
    int          n_resp, n_ld, n_st;
    logic [63:0] rng = 64'd39;

    mem_unit_top uut (
        .clk_i (clk), .arst_n_i (arst_n), .req_valid_i (req_valid), .req_instr_i (req_instr),
        .req_addr_i (req_addr), .req_data_i (req_data), .req_rd_i (req_rd), .kill_i (kill),
        .busy_o (busy), .resp_valid_o (resp_valid), .resp_data_o (resp_data),
        .resp_rd_o (resp_rd), .resp_addr_o (resp_addr), .resp_xcpt_ma_o (resp_xcpt_ma),
        .resp_xcpt_bus_o (resp_xcpt_bus), .is_load_o (is_load), .is_store_o (is_store)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;            // 8 ns period
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the DUT stopped answering after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Pulse counters, sampled mid-cycle
    always @(negedge clk) begin
        if (resp_valid) n_resp <= n_resp + 1;
        if (is_load)    n_ld   <= n_ld + 1;
        if (is_store)   n_st   <= n_st + 1;
    end

    function automatic logic [63:0] rand_word();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 7);
        rng = rng ^ (rng << 17);
        return rng;
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
            n_err++;
        end
    endtask

    task automatic add_entry(input mem_unit_pkg::instr_type_e instr, input logic [39:0] addr,
                             input logic [63:0] data, input logic kl, input logic extra);
        tbl_instr[n_tests] = instr;
        tbl_addr[n_tests]  = addr;
        tbl_data[n_tests]  = data;
        tbl_rd[n_tests]    = 5'((n_tests * 7) % 31 + 1);   // Nonzero, varies per test
        tbl_kill[n_tests]  = kl;
        tbl_extra[n_tests] = extra;
        n_tests++;
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic predict(input int i);
        logic [63:0] old, res, d;
        logic [39:0] a;
        logic        io, wr;
        a   = tbl_addr[i];
        d   = tbl_data[i];
        old = shadow_mem[a[6:3]];
        io  = (a >= mem_unit_pkg::IO_BASE_ADDR) && (a < mem_unit_pkg::IO_END_ADDR);
        exp_data[i] = '0;
        exp_ma[i]   = 1'b0;
        exp_bus[i]  = io && !tbl_kill[i];       // Only a timeout gives a bus error
        exp_ld[i]   = 1'b0;
        exp_st[i]   = 1'b0;
        chk_rd[i]   = 1'b0;
        if (tbl_kill[i] || io)
            return;                             // Never reaches memory
        exp_ld[i] = (tbl_instr[i] == mem_unit_pkg::LD);
        exp_st[i] = (tbl_instr[i] == mem_unit_pkg::SD);
        chk_rd[i] = 1'b1;
        if (a[2:0] != 3'b000) begin
            exp_ma[i] = 1'b1;                   // Memory left alone
            return;
        end
        exp_data[i] = old;
        wr  = 1'b1;
        res = d;
        case (tbl_instr[i])
            mem_unit_pkg::LD: wr = 1'b0;
            mem_unit_pkg::LR_D: begin
                wr         = 1'b0;
                resv_valid = 1'b1;
                resv_addr  = a;
            end
            mem_unit_pkg::SC_D: begin
                wr          = resv_valid && (resv_addr == a);
                exp_data[i] = wr ? 64'd0 : 64'd1;
                resv_valid  = 1'b0;
            end
            mem_unit_pkg::AMO_ADDD:  res = old + d;
            mem_unit_pkg::AMO_XORD:  res = old ^ d;
            mem_unit_pkg::AMO_ANDD:  res = old & d;
            mem_unit_pkg::AMO_ORD:   res = old | d;
            mem_unit_pkg::AMO_MIND:  res = ($signed(old) <= $signed(d)) ? old : d;
            mem_unit_pkg::AMO_MAXD:  res = ($signed(old) >= $signed(d)) ? old : d;
            mem_unit_pkg::AMO_MINDU: res = (old <= d) ? old : d;
            mem_unit_pkg::AMO_MAXDU: res = (old >= d) ? old : d;
            default: ;                          // SD and swap take the new data
        endcase
        if (wr && tbl_instr[i] != mem_unit_pkg::SC_D && a == resv_addr)
            resv_valid = 1'b0;                  // Write hit on the reserved doubleword
        if (wr)
            shadow_mem[a[6:3]] = res;
    endtask

    task automatic apply_entry(input int i);
        int err0, ld0, st0, lat, exp_lat;
        err0 = n_err;
        ld0  = n_ld;
        st0  = n_st;
        lat  = 0;
        // Cycles from accept edge to response
        if (tbl_kill[i])
            exp_lat = 1;
        else if (exp_bus[i])
            exp_lat = mem_unit_pkg::WAIT_LIMIT + 2;
        else
            exp_lat = mem_unit_pkg::MEM_LATENCY + 1;
        @(posedge clk);
        #1;
        check("busy before request", 64'(busy), 64'd0);
        req_valid = 1'b1;
        req_instr = tbl_instr[i];
        req_addr  = tbl_addr[i];
        req_data  = tbl_data[i];
        req_rd    = tbl_rd[i];
        kill      = tbl_kill[i];
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        kill      = 1'b0;                       // Kill only counts with the valid
        if (tbl_extra[i]) begin
            check("busy after accept", 64'(busy), 64'd1);
            req_valid = 1'b1;                   // Must be ignored
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            lat       = 1;
        end
        @(negedge clk);
        while (!resp_valid) begin
            lat++;
            @(negedge clk);
        end
        check("response latency", 64'(lat), 64'(exp_lat));
        check("busy at response", 64'(busy), 64'd0);
        check("resp data", resp_data, exp_data[i]);
        check("resp addr", 64'(resp_addr), 64'(tbl_addr[i]));
        check("misaligned flag", 64'(resp_xcpt_ma), 64'(exp_ma[i]));
        check("bus error flag", 64'(resp_xcpt_bus), 64'(exp_bus[i]));
        if (chk_rd[i])
            check("resp rd", 64'(resp_rd), 64'(tbl_rd[i]));
        check("load strobes", 64'(n_ld - ld0), 64'(exp_ld[i]));
        check("store strobes", 64'(n_st - st0), 64'(exp_st[i]));
        if (n_err != err0)
            n_bad_tests++;
        $display("test %0d %s addr %h: %s", i, tbl_instr[i].name(), tbl_addr[i],
                 (n_err == err0) ? "pass" : "error");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        arst_n = 1'b0; req_valid = 1'b0; kill = 1'b0;
        req_instr = mem_unit_pkg::NOP; req_addr = '0; req_data = '0; req_rd = '0;
        n_tests = 0; n_err = 0; n_bad_tests = 0; cycles = 0;
        n_resp = 0; n_ld = 0; n_st = 0;
        resv_valid = 1'b0; resv_addr = '0;
        add_entry(mem_unit_pkg::SD, 40'h00, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h00, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::SD, 40'h08, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h08, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::SD, 40'h10, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::AMO_SWAPD, 40'h10, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::AMO_ADDD, 40'h10, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::AMO_XORD, 40'h10, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::AMO_ANDD, 40'h10, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::AMO_ORD, 40'h10, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h10, 64'd0, 0, 0);
        // Signed and unsigned ordering with negative values
        add_entry(mem_unit_pkg::SD, 40'h18, 64'hFFFF_FFFF_FFFF_FF00, 0, 0);
        add_entry(mem_unit_pkg::AMO_MIND, 40'h18, 64'd5, 0, 0);
        add_entry(mem_unit_pkg::AMO_MAXD, 40'h18, 64'd5, 0, 0);
        add_entry(mem_unit_pkg::AMO_MINDU, 40'h18, 64'h8000_0000_0000_0000, 0, 0);
        add_entry(mem_unit_pkg::AMO_MAXDU, 40'h18, 64'h8000_0000_0000_0000, 0, 0);
        add_entry(mem_unit_pkg::AMO_MIND, 40'h18, 64'hFFFF_FFFF_FFFF_FFFF, 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h18, 64'd0, 0, 0);
        // LR/SC pairs
        add_entry(mem_unit_pkg::SD, 40'h20, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LR_D, 40'h20, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::SC_D, 40'h20, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h20, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::SC_D, 40'h20, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h20, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::LR_D, 40'h20, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::SD, 40'h20, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::SC_D, 40'h20, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h20, 64'd0, 0, 0);
        // Misaligned, killed, IO window, extra pulse while busy
        add_entry(mem_unit_pkg::SD, 40'h13, rand_word(), 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h10, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::SD, 40'h08, rand_word(), 1, 0);
        add_entry(mem_unit_pkg::LD, 40'h08, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h00_4000_0000, 64'd0, 0, 0);
        add_entry(mem_unit_pkg::LD, 40'h00, 64'd0, 0, 1);
        for (int i = 0; i < n_tests; i++)
            predict(i);
        cycle_limit = 20 * n_tests + 50;
        repeat (3) @(posedge clk);              // Reset for 3 cycles
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < n_tests; i++)
            apply_entry(i);
        repeat (12) @(posedge clk);             // Room for a stray response
        check("response count", 64'(n_resp), 64'(n_tests));
        $display("tests %0d, failed tests %0d, errors %0d", n_tests, n_bad_tests, n_err);
        if (n_err == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
mem_unit_pkg.sv
wait_timer.sv
mem_ctrl_fsm.sv
dcache_interface.sv
dmem_model.sv
mem_unit_top.sv
tb_mem_unit.sv
